// ==== hdl/plic_axil_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// PLIC register block: AXI4-Lite slave, config registers,
// claim/complete decode into one-hot pulses
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module plic_axil_regs (
  input  wire logic                        clk_i,
  input  wire logic                        rst_n_i,
  // Write channels
  input  wire logic [plic_pkg::addr_w-1:0] s_axil_awaddr_i,
  input  wire logic                        s_axil_awvalid_i,
  output logic                             s_axil_awready_o,
  input  wire logic [plic_pkg::data_w-1:0] s_axil_wdata_i,
  input  wire logic                        s_axil_wvalid_i,
  output logic                             s_axil_wready_o,
  output logic [1:0]                       s_axil_bresp_o,
  output logic                             s_axil_bvalid_o,
  input  wire logic                        s_axil_bready_i,
  // Read channels
  input  wire logic [plic_pkg::addr_w-1:0] s_axil_araddr_i,
  input  wire logic                        s_axil_arvalid_i,
  output logic                             s_axil_arready_o,
  output logic [plic_pkg::data_w-1:0]      s_axil_rdata_o,
  output logic [1:0]                       s_axil_rresp_o,
  output logic                             s_axil_rvalid_o,
  input  wire logic                        s_axil_rready_i,
  // Core side
  plic_cfg_if.regs                         cfg
);
  import plic_pkg::*;

  // Register selected by an address
  typedef enum logic [2:0] {
    sel_none, sel_prio, sel_ip, sel_le, sel_ie, sel_thresh, sel_cc, sel_msip
  } reg_sel_e;

  // Config storage
  prio_t                 prio_q;
  trig_mode_e            le_q [num_src];
  logic [num_src-1:0]    ie_q [num_target];
  logic [prio_w-1:0]     thresh_q [num_target];
  logic [num_target-1:0] msip_q;

  // Handshake state
  logic              bvalid_q;
  logic              rvalid_q;
  logic              wr_en;
  logic              rd_en;
  reg_sel_e          wr_sel;
  reg_sel_e          rd_sel;
  int unsigned       wr_idx;
  int unsigned       rd_idx;
  logic [data_w-1:0] rd_data;

  // Address to register and index, unaligned never hits
  function automatic reg_sel_e decode(
    input  logic [addr_w-1:0] addr,
    output int unsigned       idx
  );
    int unsigned a;
    reg_sel_e    sel;
    a   = 32'(addr);
    sel = sel_none;
    idx = 0;
    if (a[1:0] == 2'b00) begin
      if (a - prio_base < 4 * num_src) begin
        sel = sel_prio;
        idx = (a - prio_base) >> 2;
      end else if (a == ip_addr) begin
        sel = sel_ip;
      end else if (a == le_addr) begin
        sel = sel_le;
      end
      for (int t = 0; t < num_target; t++) begin
        if (a == ie_base + 4 * t) begin
          sel = sel_ie;
          idx = t;
        end
        if (a == thresh_base + 8 * t) begin
          sel = sel_thresh;
          idx = t;
        end
        if (a == cc_base + 8 * t) begin
          sel = sel_cc;
          idx = t;
        end
        if (a == msip_base + 4 * t) begin
          sel = sel_msip;
          idx = t;
        end
      end
    end
    return sel;
  endfunction

  always_comb begin
    wr_sel = decode(s_axil_awaddr_i, wr_idx);
    rd_sel = decode(s_axil_araddr_i, rd_idx);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // AW and W taken together, held off while B pending
  assign wr_en            = s_axil_awvalid_i && s_axil_wvalid_i && !bvalid_q;
  assign s_axil_awready_o = wr_en;
  assign s_axil_wready_o  = wr_en;
  assign rd_en            = s_axil_arvalid_i && !rvalid_q;
  assign s_axil_arready_o = !rvalid_q;
  assign s_axil_bvalid_o  = bvalid_q;
  assign s_axil_rvalid_o  = rvalid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_en) bvalid_q <= 1'b1;
      else if (s_axil_bready_i) bvalid_q <= 1'b0;
      if (rd_en) rvalid_q <= 1'b1;
      else if (s_axil_rready_i) rvalid_q <= 1'b0;
    end
  end

  // Response payload, frozen until taken
  always_ff @(posedge clk_i) begin
    if (wr_en) s_axil_bresp_o <= (wr_sel == sel_none) ? resp_slverr : resp_okay;
    if (rd_en) begin
      s_axil_rdata_o <= rd_data;
      s_axil_rresp_o <= (rd_sel == sel_none) ? resp_slverr : resp_okay;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q   <= '0;
      ie_q     <= '{default: '0};
      thresh_q <= '{default: '0};
      msip_q   <= '0;
      for (int s = 0; s < num_src; s++) le_q[s] <= trig_level;
    end else if (wr_en) begin
      // Source 0 priority stays zero
      for (int s = 1; s < num_src; s++) begin
        if (wr_sel == sel_prio && wr_idx == s) prio_q[s] <= s_axil_wdata_i[prio_w-1:0];
      end
      if (wr_sel == sel_le) begin
        for (int s = 0; s < num_src; s++) le_q[s] <= trig_mode_e'(s_axil_wdata_i[s]);
      end
      for (int t = 0; t < num_target; t++) begin
        if (wr_sel == sel_ie && wr_idx == t) ie_q[t] <= {s_axil_wdata_i[num_src-1:1], 1'b0};
        if (wr_sel == sel_thresh && wr_idx == t) thresh_q[t] <= s_axil_wdata_i[prio_w-1:0];
        if (wr_sel == sel_msip && wr_idx == t) msip_q[t] <= s_axil_wdata_i[0];
      end
    end
  end

  assign cfg.prio      = prio_q;
  assign cfg.le        = le_q;
  assign cfg.ie        = ie_q;
  assign cfg.threshold = thresh_q;
  assign cfg.msip      = msip_q;

  // Read mux, unmapped reads as zero
  always_comb begin
    rd_data = '0;
    case (rd_sel)
      sel_prio: begin
        for (int s = 1; s < num_src; s++) begin
          if (rd_idx == s) rd_data[prio_w-1:0] = prio_q[s];
        end
      end
      sel_ip: rd_data[num_src-1:0] = cfg.ip;
      sel_le: begin
        for (int s = 0; s < num_src; s++) rd_data[s] = le_q[s];
      end
      default: begin
        for (int t = 0; t < num_target; t++) begin
          if (rd_idx == t) begin
            if (rd_sel == sel_ie) rd_data[num_src-1:0] = ie_q[t];
            if (rd_sel == sel_thresh) rd_data[prio_w-1:0] = thresh_q[t];
            if (rd_sel == sel_cc) rd_data[src_w-1:0] = cfg.irq_id[t];
            if (rd_sel == sel_msip) rd_data[0] = msip_q[t];
          end
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Claim and complete
  ////////////////////////////////////////////////////////////////////////////

  // Claim fires on AR acceptance only, so once per read
  // ID 0 never pulses
  always_comb begin
    cfg.claim    = '0;
    cfg.complete = '0;
    for (int t = 0; t < num_target; t++) begin
      for (int s = 1; s < num_src; s++) begin
        if (rd_en && rd_sel == sel_cc && rd_idx == t &&
            cfg.irq_id[t] == src_w'(s))
          cfg.claim[s] = 1'b1;
        if (wr_en && wr_sel == sel_cc && wr_idx == t &&
            s_axil_wdata_i[src_w-1:0] == src_w'(s))
          cfg.complete[s] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/plic_cfg_if.sv ====
////////////////////////////////////////////////////////////////////////////
// PLIC internal bundle: configuration from the register block,
// claim/complete pulses, pending bits and winning IDs, with modports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface plic_cfg_if;
  import plic_pkg::*;

  // Configuration registers
  prio_t                 prio;
  trig_mode_e            le [num_src];
  logic [num_src-1:0]    ie [num_target];
  logic [prio_w-1:0]     threshold [num_target];
  logic [num_target-1:0] msip;

  // One-hot single cycle pulses, bit = source ID
  logic [num_src-1:0] claim;
  logic [num_src-1:0] complete;

  // Raw sources from the pins
  logic [num_src-1:0] src;

  // Core status
  logic [num_src-1:0] ip;
  id_vec_t            irq_id;

  // Register block side
  modport regs (
    output prio, le, ie, threshold, msip, claim, complete,
    input  ip, irq_id
  );

  // Gateway side
  modport gateway (
    input  src, le, claim, complete,
    output ip
  );

  // Top level glue
  modport top (
    output src, irq_id,
    input  prio, ie, threshold, msip, ip
  );

endinterface

`default_nettype wire

// ==== hdl/plic_gateway.sv ====
////////////////////////////////////////////////////////////////////////////
// PLIC gateway: level/edge pending bits with in-service gating
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module plic_gateway (
  input  wire logic   clk_i,
  input  wire logic   rst_n_i,
  plic_cfg_if.gateway cfg
);
  import plic_pkg::*;

  // Delayed sources for edge detect
  logic [num_src-1:0] src_q;
  // Pending and in-service
  logic [num_src-1:0] ip_q;
  logic [num_src-1:0] ia_q;
  logic [num_src-1:0] ip_d;
  logic [num_src-1:0] ia_d;

  always_comb begin
    for (int s = 0; s < num_src; s++) begin
      if (cfg.le[s] == trig_edge) begin
        // Sticky until claimed
        ip_d[s] = ip_q[s] | (cfg.src[s] & ~src_q[s] & ~ia_q[s]);
      end else begin
        // Level follows the pin while not in service
        ip_d[s] = cfg.src[s] & ~ia_q[s];
      end
      if (cfg.claim[s]) ip_d[s] = 1'b0;
      ia_d[s] = (ia_q[s] & ~cfg.complete[s]) | cfg.claim[s];
    end
    // Reserved source never pends
    ip_d[0] = 1'b0;
    ia_d[0] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q <= '0;
      ip_q  <= '0;
      ia_q  <= '0;
    end else begin
      src_q <= cfg.src;
      ip_q  <= ip_d;
      ia_q  <= ia_d;
    end
  end

  assign cfg.ip = ip_q;

endmodule

`default_nettype wire

// ==== hdl/plic_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// PLIC shared definitions: platform size, field widths, register map,
// AXI4-Lite response codes and interrupt source types
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package plic_pkg;

  // Platform size, source 0 reserved as "no interrupt"
  localparam int num_src    = 10;
  localparam int num_target = 2;
  localparam int src_w      = 4;
  localparam int prio_w     = 3;

  // AXI4-Lite bus widths
  localparam int addr_w = 12;
  localparam int data_w = 32;

  // Register map, byte offsets
  localparam int unsigned prio_base   = 32'h000;
  localparam int unsigned ip_addr     = 32'h080;
  localparam int unsigned le_addr     = 32'h084;
  localparam int unsigned ie_base     = 32'h100;
  localparam int unsigned thresh_base = 32'h200;
  localparam int unsigned cc_base     = 32'h204;
  localparam int unsigned msip_base   = 32'h300;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Per-source trigger mode
  typedef enum logic {
    trig_level = 1'b0,
    trig_edge  = 1'b1
  } trig_mode_e;

  // All source priorities, index = source ID
  typedef logic [num_src-1:0][prio_w-1:0] prio_t;

  // Winning source ID per target
  typedef logic [num_target-1:0][src_w-1:0] id_vec_t;

endpackage

`default_nettype wire

// ==== hdl/plic_target.sv ====
////////////////////////////////////////////////////////////////////////////
// PLIC target notifier: priority search over pending, enabled sources
// and registered interrupt request with winning ID
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module plic_target (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire logic [plic_pkg::num_src-1:0] ip_i,
  input  wire logic [plic_pkg::num_src-1:0] ie_i,
  input  wire plic_pkg::prio_t              prio_i,
  input  wire logic [plic_pkg::prio_w-1:0]  threshold_i,
  output logic                              irq_o,
  output logic [plic_pkg::src_w-1:0]        irq_id_o
);
  import plic_pkg::*;

  // Current best candidate
  logic              found;
  logic [prio_w-1:0] best_prio;
  logic [src_w-1:0]  best_id;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////////////

  // Linear scan from low IDs
  // Strict compare keeps the lowest index on ties
  always_comb begin
    found     = 1'b0;
    best_prio = '0;
    best_id   = '0;
    for (int s = 1; s < num_src; s++) begin
      if (ip_i[s] && ie_i[s] && (!found || prio_i[s] > best_prio)) begin
        found     = 1'b1;
        best_prio = prio_i[s];
        best_id   = src_w'(s);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////

  // Request only above threshold
  // ID still reported for a low priority winner
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_o    <= 1'b0;
      irq_id_o <= '0;
    end else begin
      irq_o    <= found && (best_prio > threshold_i);
      irq_id_o <= best_id;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/plic_top.sv ====
////////////////////////////////////////////////////////////////////////////
// PLIC top: AXI4-Lite register block, gateway and one notifier per target
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module plic_top (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  // AXI4-Lite slave
  input  wire logic [plic_pkg::addr_w-1:0]     s_axil_awaddr_i,
  input  wire logic                            s_axil_awvalid_i,
  output wire logic                            s_axil_awready_o,
  input  wire logic [plic_pkg::data_w-1:0]     s_axil_wdata_i,
  input  wire logic                            s_axil_wvalid_i,
  output wire logic                            s_axil_wready_o,
  output wire logic [1:0]                      s_axil_bresp_o,
  output wire logic                            s_axil_bvalid_o,
  input  wire logic                            s_axil_bready_i,
  input  wire logic [plic_pkg::addr_w-1:0]     s_axil_araddr_i,
  input  wire logic                            s_axil_arvalid_i,
  output wire logic                            s_axil_arready_o,
  output wire logic [plic_pkg::data_w-1:0]     s_axil_rdata_o,
  output wire logic [1:0]                      s_axil_rresp_o,
  output wire logic                            s_axil_rvalid_o,
  input  wire logic                            s_axil_rready_i,
  // Interrupt sources, bit 0 tied low
  input  wire logic [plic_pkg::num_src-1:0]    intr_src_i,
  // Per target notification
  output wire logic [plic_pkg::num_target-1:0] irq_o,
  output wire plic_pkg::id_vec_t               irq_id_o,
  output wire logic [plic_pkg::num_target-1:0] msip_o
);
  import plic_pkg::*;

  plic_cfg_if cfg ();

  // Glue between pins and the bundle
  assign cfg.src    = intr_src_i;
  assign cfg.irq_id = irq_id_o;
  assign msip_o     = cfg.msip;

  plic_axil_regs u_regs (
    .clk_i,
    .rst_n_i,
    .s_axil_awaddr_i,
    .s_axil_awvalid_i,
    .s_axil_awready_o,
    .s_axil_wdata_i,
    .s_axil_wvalid_i,
    .s_axil_wready_o,
    .s_axil_bresp_o,
    .s_axil_bvalid_o,
    .s_axil_bready_i,
    .s_axil_araddr_i,
    .s_axil_arvalid_i,
    .s_axil_arready_o,
    .s_axil_rdata_o,
    .s_axil_rresp_o,
    .s_axil_rvalid_o,
    .s_axil_rready_i,
    .cfg              (cfg)
  );

  plic_gateway u_gateway (
    .clk_i,
    .rst_n_i,
    .cfg     (cfg)
  );

  // One notifier per target, shared pending bits
  for (genvar t = 0; t < num_target; t++) begin : gen_target
    plic_target u_target (
      .clk_i,
      .rst_n_i,
      .ip_i        (cfg.ip),
      .ie_i        (cfg.ie[t]),
      .prio_i      (cfg.prio),
      .threshold_i (cfg.threshold[t]),
      .irq_o       (irq_o[t]),
      .irq_id_o    (irq_id_o[t])
    );
  end

endmodule

`default_nettype wire

// ==== plic.f ====
hdl/plic_pkg.sv
hdl/plic_cfg_if.sv
hdl/plic_axil_regs.sv
hdl/plic_gateway.sv
hdl/plic_target.sv
hdl/plic_top.sv
test/plic_sva.sv
test/plic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PLIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module plic_tb -f plic.f -o plic_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/plic_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// ==== test/plic_sva.sv ====
////////////////////////////////////////////////////////////////////////////
// PLIC assertions: AXI4-Lite response stability, interrupt output sanity,
// bound into the top level
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module plic_sva (
  input wire logic                  clk_i,
  input wire logic                  rst_n_i,
  input wire logic                  bvalid_i,
  input wire logic                  bready_i,
  input wire logic [1:0]            bresp_i,
  input wire logic                  rvalid_i,
  input wire logic                  rready_i,
  input wire logic [31:0]           rdata_i,
  input wire logic [1:0]            rresp_i,
  input wire logic [1:0]            irq_i,
  input wire plic_pkg::id_vec_t     irq_id_i,
  input wire logic [1:0]            msip_i
);

  // Write response held until taken
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("bvalid dropped or bresp changed under back-pressure");

  // Read response held until taken
  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else $error("rvalid dropped or read payload changed under back-pressure");

  // A request always names a real source
  a_irq_id0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_i[0] |-> irq_id_i[0] != '0)
    else $error("irq for target 0 with ID 0");
  a_irq_id1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_i[1] |-> irq_id_i[1] != '0)
    else $error("irq for target 1 with ID 0");

  a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(irq_i) && !$isunknown(msip_i))
    else $error("irq or msip unknown");

endmodule

bind plic_top plic_sva u_sva (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .bvalid_i (s_axil_bvalid_o),
  .bready_i (s_axil_bready_i),
  .bresp_i  (s_axil_bresp_o),
  .rvalid_i (s_axil_rvalid_o),
  .rready_i (s_axil_rready_i),
  .rdata_i  (s_axil_rdata_o),
  .rresp_i  (s_axil_rresp_o),
  .irq_i    (irq_o),
  .irq_id_i (irq_id_o),
  .msip_i   (msip_o)
);

`default_nettype wire

// ==== test/plic_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the PLIC with clock, reset, LFSR stimulus, AXI4-Lite tasks,
// reference model of registers, gateway and arbitration, and a watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module plic_tb;
  import plic_pkg::*;

  localparam int iters           = 40;
  localparam int cycles_per_iter = 400;
  localparam int timeout_ns      = 5 * iters * cycles_per_iter * 4;

  logic              clk;
  logic              rst_n;
  logic [addr_w-1:0] awaddr;
  logic              awvalid;
  wire logic         awready;
  logic [data_w-1:0] wdata;
  logic              wvalid;
  wire logic         wready;
  wire logic [1:0]   bresp;
  wire logic         bvalid;
  logic              bready;
  logic [addr_w-1:0] araddr;
  logic              arvalid;
  wire logic         arready;
  wire logic [31:0]  rdata;
  wire logic [1:0]   rresp;
  wire logic         rvalid;
  logic              rready;
  logic [num_src-1:0] intr_src;
  wire logic [num_target-1:0] irq;
  wire id_vec_t               irq_id;
  wire logic [num_target-1:0] msip;

  // Reference model state
  logic [prio_w-1:0]     m_prio [num_src];
  logic [num_src-1:0]    m_ie [num_target];
  logic [prio_w-1:0]     m_thr [num_target];
  logic [num_src-1:0]    m_le;
  logic [num_target-1:0] m_msip;
  logic [num_src-1:0]    m_src;
  logic [num_src-1:0]    m_ep;
  logic [num_src-1:0]    m_ia;

  logic [31:0] lfsr_q;
  int          error_count;

  plic_top plic_top_i (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready),
    .intr_src_i       (intr_src),
    .irq_o            (irq),
    .irq_id_o         (irq_id),
    .msip_o           (msip)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hang guard
  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns, the run did not finish", timeout_ns);
    $display("Simulation failed");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Pending as the gateway should hold it
  function automatic logic [num_src-1:0] model_ip();
    logic [num_src-1:0] p;
    for (int s = 0; s < num_src; s++)
      p[s] = m_le[s] ? m_ep[s] : (m_src[s] & ~m_ia[s]);
    p[0] = 1'b0;
    return p;
  endfunction

  // Highest priority wins and the first index breaks a tie
  task automatic model_arb(input int t, output logic exp_irq, output logic [src_w-1:0] exp_id);
    logic [num_src-1:0] p;
    logic               found;
    logic [prio_w-1:0]  best;
    p       = model_ip();
    found   = 1'b0;
    best    = '0;
    exp_id  = '0;
    for (int s = 1; s < num_src; s++) begin
      if (p[s] && m_ie[t][s] && (!found || m_prio[s] > best)) begin
        found  = 1'b1;
        best   = m_prio[s];
        exp_id = src_w'(s);
      end
    end
    exp_irq = found && (best > m_thr[t]);
  endtask

  task automatic settle();
    repeat (3) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge clk);
    repeat (rand_bits(2)) @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Random stall on the response
    bready = rand_bits(1);
    #1;
    while (!(bvalid && bready)) begin
      @(negedge clk);
      bready = rand_bits(1);
      #1;
    end
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [addr_w-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clk);
    repeat (rand_bits(2)) @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    rready  = rand_bits(1);
    #1;
    while (!(rvalid && rready)) begin
      @(negedge clk);
      rready = rand_bits(1);
      #1;
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Mapped write mirrored into the model
  task automatic cfg_write(input string name, input logic [addr_w-1:0] addr,
                           input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_val({name, " bresp"}, resp_okay, resp);
    if (addr < 12'h028) begin
      if (addr[11:2] != 0) m_prio[addr[11:2]] = data[prio_w-1:0];
    end else if (addr == 12'h084) begin
      m_le = data[num_src-1:0];
    end
    for (int t = 0; t < num_target; t++) begin
      if (addr == 12'h100 + 4 * t) m_ie[t] = {data[num_src-1:1], 1'b0};
      if (addr == 12'h200 + 8 * t) m_thr[t] = data[prio_w-1:0];
      if (addr == 12'h300 + 4 * t) m_msip[t] = data[0];
      // Complete frees the source whatever the target
      if (addr == 12'h204 + 8 * t && data[src_w-1:0] < num_src && data[src_w-1:0] != 0)
        m_ia[data[src_w-1:0]] = 1'b0;
    end
  endtask

  task automatic read_check(input string name, input logic [addr_w-1:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_val({name, " rresp"}, resp_okay, resp);
    check_val(name, exp, data);
  endtask

  task automatic verify_regs(input string name);
    for (int s = 0; s < num_src; s++)
      read_check({name, " prio"}, 12'(4 * s), (s == 0) ? 32'h0 : 32'(m_prio[s]));
    read_check({name, " le"}, 12'h084, 32'(m_le));
    for (int t = 0; t < num_target; t++) begin
      read_check({name, " ie"}, 12'(12'h100 + 4 * t), 32'(m_ie[t]));
      read_check({name, " thresh"}, 12'(12'h200 + 8 * t), 32'(m_thr[t]));
      read_check({name, " msip reg"}, 12'(12'h300 + 4 * t), 32'(m_msip[t]));
    end
    check_val({name, " msip pin"}, 32'(m_msip), 32'(msip));
  endtask

  task automatic check_outputs(input string name);
    logic             exp_irq;
    logic [src_w-1:0] exp_id;
    for (int t = 0; t < num_target; t++) begin
      model_arb(t, exp_irq, exp_id);
      check_val({name, " irq"}, 32'(exp_irq), 32'(irq[t]));
      check_val({name, " irq_id"}, 32'(exp_id), 32'(irq_id[t]));
    end
  endtask

  // Drive the pins and pend rising edges of edge sources
  task automatic set_src(input logic [num_src-1:0] val);
    logic [num_src-1:0] v;
    v    = val & ~num_src'(1);
    @(negedge clk);
    m_ep = m_ep | (m_le & v & ~m_src & ~m_ia);
    m_src    = v;
    intr_src = v;
  endtask

  // cc read that claims the returned ID
  task automatic claim_check(input string name, input int t, output logic [src_w-1:0] id);
    logic             exp_irq;
    logic [31:0]      data;
    logic [1:0]       resp;
    settle();
    model_arb(t, exp_irq, id);
    axi_read(12'(12'h204 + 8 * t), data, resp);
    check_val({name, " cc rresp"}, resp_okay, resp);
    check_val({name, " claim id"}, 32'(id), data);
    if (id != 0) begin
      m_ia[id] = 1'b1;
      m_ep[id] = 1'b0;
    end
    settle();
    read_check({name, " ip after claim"}, 12'h080, 32'(model_ip()));
  endtask

  task automatic release_all(input string name);
    for (int s = 1; s < num_src; s++)
      if (m_ia[s]) cfg_write(name, 12'h204, 32'(s));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_regs();
    int          kind;
    int          idx;
    logic [31:0] data;
    for (int i = 0; i < iters; i++) begin
      kind = rand_bits(8) % 5;
      data = rand_bits(32);
      idx  = rand_bits(8) % num_target;
      case (kind)
        0: cfg_write("regs", 12'(4 * (rand_bits(8) % num_src)), data);
        1: cfg_write("regs", 12'(12'h100 + 4 * idx), data);
        2: cfg_write("regs", 12'(12'h200 + 8 * idx), data);
        3: cfg_write("regs", 12'h084, data);
        default: cfg_write("regs", 12'(12'h300 + 4 * idx), data);
      endcase
      verify_regs("regs");
    end
    cfg_write("regs", 12'h084, 32'h0);
  endtask

  task automatic test_arb();
    for (int i = 0; i < iters; i++) begin
      // Narrow range forces ties
      for (int s = 1; s < num_src; s++)
        if (rand_bits(1)) cfg_write("arb", 12'(4 * s), rand_bits(2));
      for (int t = 0; t < num_target; t++) begin
        cfg_write("arb", 12'(12'h100 + 4 * t), rand_bits(10));
        cfg_write("arb", 12'(12'h200 + 8 * t), rand_bits(2));
      end
      set_src(rand_bits(10));
      settle();
      check_outputs("arb");
    end
  endtask

  task automatic test_claim();
    logic [src_w-1:0] id;
    int               t;
    for (int i = 0; i < iters; i++) begin
      if (rand_bits(2) == 0) set_src(rand_bits(10));
      t = rand_bits(1);
      claim_check("claim", t, id);
      check_outputs("claim");
      if (id != 0 && rand_bits(1)) begin
        cfg_write("complete", 12'(12'h204 + 8 * t), 32'(id));
        settle();
        read_check("ip after complete", 12'h080, 32'(model_ip()));
        check_outputs("complete");
      end
    end
    set_src('0);
    release_all("claim cleanup");
  endtask

  task automatic test_edge();
    logic [src_w-1:0] id;
    set_src('0);
    settle();
    cfg_write("edge", 12'h084, 32'h3fe);
    cfg_write("edge", 12'h100, 32'h3fe);
    for (int i = 0; i < iters; i++) begin
      set_src(rand_bits(10));
      // One cycle pulse half the time
      if (rand_bits(1)) set_src('0);
      settle();
      read_check("edge ip", 12'h080, 32'(model_ip()));
      check_outputs("edge");
      claim_check("edge", 0, id);
      if (id != 0) begin
        cfg_write("edge complete", 12'h204, 32'(id));
        settle();
        read_check("edge ip after complete", 12'h080, 32'(model_ip()));
      end
    end
    set_src('0);
    release_all("edge cleanup");
    // Each claim retires one pending edge source
    for (int s = 1; s < num_src; s++)
      if (m_ep != '0) claim_check("edge drain", 0, id);
    release_all("edge cleanup");
    cfg_write("edge", 12'h084, 32'h0);
  endtask

  task automatic test_unmapped();
    logic [addr_w-1:0] bad [8];
    logic [31:0]       data;
    logic [1:0]        resp;
    bad = '{12'h028, 12'h088, 12'h108, 12'h210, 12'h308, 12'h400, 12'h101, 12'hffc};
    for (int i = 0; i < 8; i++) begin
      axi_write(bad[i], rand_bits(32), resp);
      check_val("unmapped bresp", resp_slverr, resp);
      axi_read(bad[i], data, resp);
      check_val("unmapped rresp", resp_slverr, resp);
      check_val("unmapped rdata", 32'h0, data);
    end
    verify_regs("unmapped");
  endtask

  initial begin
    lfsr_q      = 32'ha273_9a42;
    error_count = 0;
    rst_n       = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    intr_src    = '0;
    m_le        = '0;
    m_msip      = '0;
    m_src       = '0;
    m_ep        = '0;
    m_ia        = '0;
    for (int s = 0; s < num_src; s++) m_prio[s] = '0;
    for (int t = 0; t < num_target; t++) begin
      m_ie[t]  = '0;
      m_thr[t] = '0;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    test_regs();
    test_arb();
    test_claim();
    test_edge();
    test_unmapped();

    settle();
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
